// ==== src/softmax_pkg.sv ====
package softmax_pkg;

  localparam int VEC_LEN = 8;

  localparam int IN_W = 8; // signed Q4.4 input
  localparam int IN_FRAC = 4;

  localparam int EXP_W = 16; // unsigned exp value
  localparam int EXP_FRAC = 8;

  localparam int ACC_W = EXP_W + $clog2(VEC_LEN); // room for VEC_LEN full-scale terms
  localparam int OUT_W = 8; // unsigned Q0.8 probability

  localparam int CNT_W = $clog2(VEC_LEN + 1); // counts 0..VEC_LEN
  localparam int IN_FIFO_DEPTH = 4;

  typedef struct packed {
    logic [ACC_W-1:0] sum;
    logic last;
  } sum_hold_t;

  typedef struct packed {
    logic [OUT_W-1:0] prob;
    logic last;
  } softmax_out_t;

  // table entry for one input code, evaluated at elaboration
  function automatic logic [EXP_W-1:0] exp_entry(input logic [IN_W-1:0] x);
    real scaled;
    scaled = real'(2 ** EXP_FRAC) * $exp(real'($signed(x)) / real'(2 ** IN_FRAC));
    if (scaled + 0.5 >= real'(2 ** EXP_W - 1)) begin
      return '1; // saturate at full scale
    end
    return EXP_W'($rtoi(scaled + 0.5)); // half up, value is never negative
  endfunction

endpackage

// ==== src/stream_fifo.sv ====
module stream_fifo #(
  parameter type item_t = logic [7:0],
  parameter int DEPTH = 4
) (
  input  logic  clk,
  input  logic  rst,
  input  item_t in_data,
  input  logic  in_valid,
  output logic  in_ready,
  output item_t out_data,
  output logic  out_valid,
  input  logic  out_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  item_t mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic wr_en;
  logic rd_en;

  assign in_ready = (count != CNT_W'(DEPTH)); // low only when full
  assign out_valid = (count != '0);
  assign out_data = mem[rd_ptr]; // head of queue

  assign wr_en = in_valid && in_ready;
  assign rd_en = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

  // a full buffer must never accept another item
  // a write while full would land on the head slot
  a_no_write_full: assert property (@(posedge clk) disable iff (rst)
    (count == CNT_W'(DEPTH)) && !rd_en |=> (count == CNT_W'(DEPTH)) && $stable(out_data));

endmodule

// ==== src/exp_lut.sv ====
module exp_lut (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [softmax_pkg::IN_W-1:0]  in_data,
  input  logic                          in_valid,
  output logic                          in_ready,
  output logic [softmax_pkg::EXP_W-1:0] out_data,
  output logic                          out_valid,
  input  logic                          out_ready
);

  localparam int ENTRIES = 2 ** softmax_pkg::IN_W;

  logic [softmax_pkg::EXP_W-1:0] rom [ENTRIES];

  // constant table, one entry per input code
  for (genvar i = 0; i < ENTRIES; i++) begin : g_rom
    assign rom[i] = softmax_pkg::exp_entry(softmax_pkg::IN_W'(i));
  end

  assign in_ready = !out_valid || out_ready; // register empty or draining

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_data <= rom[in_data];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

endmodule

// ==== src/exp_sum_accumulator.sv ====
module exp_sum_accumulator (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [softmax_pkg::EXP_W-1:0] in_data,
  input  logic                          in_valid,
  output logic                          in_ready,
  output logic [softmax_pkg::ACC_W-1:0] sum_data,
  output logic                          sum_valid,
  input  logic                          sum_ready
);

  logic [softmax_pkg::CNT_W-1:0] count; // elements taken so far
  logic [softmax_pkg::ACC_W-1:0] acc;
  logic [softmax_pkg::ACC_W-1:0] acc_base;
  logic take;

  // vector complete, sum on offer
  assign sum_valid = (count == softmax_pkg::CNT_W'(softmax_pkg::VEC_LEN));
  assign sum_data = acc;
  assign in_ready = !sum_valid;
  assign take = in_valid && in_ready;

  assign acc_base = (count == '0) ? '0 : acc; // restart on first element

  always_ff @(posedge clk) begin
    if (take) begin
      acc <= acc_base + softmax_pkg::ACC_W'(in_data);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (sum_valid && sum_ready) begin
      count <= '0;
    end else if (take) begin
      count <= count + 1'b1;
    end
  end

  a_count_range: assert property (@(posedge clk) disable iff (rst)
    count <= softmax_pkg::CNT_W'(softmax_pkg::VEC_LEN));

  // an offered sum is held until it is taken
  a_sum_hold: assert property (@(posedge clk) disable iff (rst)
    sum_valid && !sum_ready |=> sum_valid && $stable(sum_data));

endmodule

// ==== src/sum_hold_buffer.sv ====
module sum_hold_buffer (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [softmax_pkg::ACC_W-1:0] sum_data,
  input  logic                          sum_valid,
  output logic                          sum_ready,
  output softmax_pkg::sum_hold_t        hold_data,
  output logic                          hold_valid,
  input  logic                          hold_ready
);

  logic [softmax_pkg::CNT_W-1:0] uses_left;
  logic [softmax_pkg::ACC_W-1:0] sum_reg;

  assign sum_ready = (uses_left == '0); // only load when empty
  assign hold_valid = !sum_ready;

  always_comb begin
    hold_data.sum = sum_reg;
    hold_data.last = (uses_left == softmax_pkg::CNT_W'(1)); // final use of this sum
  end

  always_ff @(posedge clk) begin
    if (sum_valid && sum_ready) begin
      sum_reg <= sum_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      uses_left <= '0;
    end else if (sum_valid && sum_ready) begin
      uses_left <= softmax_pkg::CNT_W'(softmax_pkg::VEC_LEN);
    end else if (hold_valid && hold_ready) begin
      uses_left <= uses_left - 1'b1;
    end
  end

  // the sum must not change across the uses of one vector
  a_sum_steady: assert property (@(posedge clk) disable iff (rst)
    hold_valid && !(hold_ready && hold_data.last) |=> $stable(sum_reg));

endmodule

// ==== src/softmax_divider.sv ====
module softmax_divider (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [softmax_pkg::EXP_W-1:0] exp_data,
  input  logic                          exp_valid,
  output logic                          exp_ready,
  input  softmax_pkg::sum_hold_t        hold_data,
  input  logic                          hold_valid,
  output logic                          hold_ready,
  output softmax_pkg::softmax_out_t     out_data,
  output logic                          out_valid,
  input  logic                          out_ready
);

  localparam int SHIFT = softmax_pkg::OUT_W + 1; // one extra bit for rounding
  localparam int NUM_W = softmax_pkg::EXP_W + SHIFT;

  logic [NUM_W-1:0] num;
  logic [NUM_W-1:0] quot;
  logic [NUM_W-1:0] rounded;
  logic [softmax_pkg::OUT_W-1:0] prob;
  logic slot_free;
  logic take;

  assign slot_free = !out_valid || out_ready;
  assign take = exp_valid && hold_valid && slot_free; // join of both streams
  assign exp_ready = hold_valid && slot_free;
  assign hold_ready = exp_valid && slot_free;

  always_comb begin
    num = {exp_data, {SHIFT{1'b0}}};
    if (hold_data.sum == '0) begin
      quot = '0; // all exps underflowed
    end else begin
      quot = num / NUM_W'(hold_data.sum);
    end
    rounded = (quot + 1'b1) >> 1;
    if (rounded > NUM_W'(2 ** softmax_pkg::OUT_W - 1)) begin
      prob = '1; // single dominant element
    end else begin
      prob = rounded[softmax_pkg::OUT_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      out_data.prob <= prob;
      out_data.last <= hold_data.last;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (slot_free) begin
      out_valid <= take;
    end
  end

  a_out_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// ==== src/fixed_softmax.sv ====
module fixed_softmax (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [softmax_pkg::IN_W-1:0] in_data,
  input  logic                         in_valid,
  output logic                         in_ready,
  output softmax_pkg::softmax_out_t    out_data,
  output logic                         out_valid,
  input  logic                         out_ready
);

  logic [softmax_pkg::IN_W-1:0] elem_data;
  logic elem_valid;
  logic elem_ready;

  logic [softmax_pkg::EXP_W-1:0] lut_data;
  logic lut_valid;
  logic lut_ready;

  logic acc_valid; // split branch to the accumulator
  logic acc_ready;
  logic buf_valid; // split branch to the exp FIFO
  logic buf_ready;

  logic [softmax_pkg::EXP_W-1:0] exp_data;
  logic exp_valid;
  logic exp_ready;

  logic [softmax_pkg::ACC_W-1:0] sum_data;
  logic sum_valid;
  logic sum_ready;

  softmax_pkg::sum_hold_t hold_data;
  logic hold_valid;
  logic hold_ready;

  stream_fifo #(
    .item_t(logic [softmax_pkg::IN_W-1:0]),
    .DEPTH (softmax_pkg::IN_FIFO_DEPTH)
  ) u_in_fifo (
    .clk(clk), .rst(rst),
    .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
    .out_data(elem_data), .out_valid(elem_valid), .out_ready(elem_ready)
  );

  exp_lut u_exp_lut (
    .clk(clk), .rst(rst),
    .in_data(elem_data), .in_valid(elem_valid), .in_ready(elem_ready),
    .out_data(lut_data), .out_valid(lut_valid), .out_ready(lut_ready)
  );

  // each branch sees valid only when the other can also take the beat
  assign lut_ready = acc_ready && buf_ready;
  assign acc_valid = lut_valid && buf_ready;
  assign buf_valid = lut_valid && acc_ready;

  exp_sum_accumulator u_acc (
    .clk(clk), .rst(rst),
    .in_data(lut_data), .in_valid(acc_valid), .in_ready(acc_ready),
    .sum_data(sum_data), .sum_valid(sum_valid), .sum_ready(sum_ready)
  );

  stream_fifo #(
    .item_t(logic [softmax_pkg::EXP_W-1:0]),
    .DEPTH (softmax_pkg::VEC_LEN) // whole vector waits for its sum
  ) u_exp_fifo (
    .clk(clk), .rst(rst),
    .in_data(lut_data), .in_valid(buf_valid), .in_ready(buf_ready),
    .out_data(exp_data), .out_valid(exp_valid), .out_ready(exp_ready)
  );

  sum_hold_buffer u_hold (
    .clk(clk), .rst(rst),
    .sum_data(sum_data), .sum_valid(sum_valid), .sum_ready(sum_ready),
    .hold_data(hold_data), .hold_valid(hold_valid), .hold_ready(hold_ready)
  );

  softmax_divider u_div (
    .clk(clk), .rst(rst),
    .exp_data(exp_data), .exp_valid(exp_valid), .exp_ready(exp_ready),
    .hold_data(hold_data), .hold_valid(hold_valid), .hold_ready(hold_ready),
    .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready)
  );

endmodule

// ==== bench/softmax_tb.sv ====
module softmax_tb;

  localparam int NUM_VEC = 40;
  localparam int NUM_ELEM = NUM_VEC * softmax_pkg::VEC_LEN;
  localparam int WATCHDOG_CYCLES = NUM_VEC * softmax_pkg::VEC_LEN * 20;
  localparam int SEED = 35898;

  logic clk;
  logic rst;
  logic [softmax_pkg::IN_W-1:0] in_data;
  logic in_valid;
  logic in_ready;
  softmax_pkg::softmax_out_t out_data;
  logic out_valid;
  logic out_ready;

  logic [softmax_pkg::IN_W-1:0] stim [$]; // every element in send order
  softmax_pkg::softmax_out_t expect_q [$];
  logic in_fire = 1'b0; // input beat taken on the last rising edge
  int idx = 0;
  int out_count = 0;
  int value_errors = 0;
  int protocol_errors = 0;

  fixed_softmax UUT (
    .clk(clk), .rst(rst),
    .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
    .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // 256 * e^(x/16), half up, clipped to 16 bits
  function automatic longint exp_of(input logic [7:0] x);
    real v;
    v = 256.0 * $exp(real'($signed(x)) / 16.0);
    if (v + 0.5 >= 65535.0) begin
      return 65535;
    end
    return longint'($rtoi(v + 0.5));
  endfunction

  function automatic logic [7:0] prob_of(input longint e, input longint s);
    longint q;
    longint r;
    if (s == 0) begin
      return 8'h00;
    end
    q = (e * 512) / s;
    r = (q + 1) / 2;
    if (r > 255) begin
      return 8'hff;
    end
    return r[7:0];
  endfunction

  task automatic build_vector(input int v);
    int val;
    for (int i = 0; i < softmax_pkg::VEC_LEN; i++) begin
      case (v)
        0: val = 16; // all 1.0
        1: val = -48; // all -3.0
        2: val = 127 - 9 * i; // top entries saturate
        3: val = -128; // every exp rounds to zero
        4: val = (i == 0) ? 127 : -128; // one element takes it all
        default: val = (v % 2) ? int'($urandom_range(0, 255)) : int'($urandom_range(0, 95)) - 48;
      endcase
      stim.push_back(8'(val));
    end
  endtask

  task automatic model_vector(input int base);
    longint sum;
    softmax_pkg::softmax_out_t item;
    sum = 0;
    for (int i = 0; i < softmax_pkg::VEC_LEN; i++) begin
      sum += exp_of(stim[base + i]);
    end
    for (int i = 0; i < softmax_pkg::VEC_LEN; i++) begin
      item.prob = prob_of(exp_of(stim[base + i]), sum);
      item.last = (i == softmax_pkg::VEC_LEN - 1);
      expect_q.push_back(item);
    end
  endtask

  always @(posedge clk) begin : check_outputs
    softmax_pkg::softmax_out_t want;
    in_fire <= !rst && in_valid && in_ready;
    if (!rst && out_valid && out_ready) begin
      if (expect_q.size() == 0) begin
        protocol_errors++;
        $display("output beat %0d arrived with no element left to match", out_count);
      end else begin
        want = expect_q.pop_front();
        a_prob: assert (out_data.prob == want.prob) else begin
          value_errors++;
          $display("FAILED out_data.prob at output %0d: got %h expected %h",
                   out_count, out_data.prob, want.prob);
        end
        a_last: assert (out_data.last == want.last) else begin
          value_errors++;
          $display("FAILED out_data.last at output %0d: got %h expected %h",
                   out_count, out_data.last, want.last);
        end
      end
      out_count++;
    end
  end

  // stalled output must hold
  a_stall_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else begin
      protocol_errors++;
      $display("out_data changed or out_valid dropped while out_ready was low");
    end

  a_reset_state: assert property (@(posedge clk) $fell(rst) |-> !out_valid && in_ready)
    else begin
      protocol_errors++;
      $display("right after reset out_valid was not low or in_ready was not high");
    end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout after %0d cycles with %0d of %0d outputs seen",
             WATCHDOG_CYCLES, out_count, NUM_ELEM);
    $display("Test failed");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    rst = 1'b1;
    in_valid = 1'b0;
    in_data = '0;
    out_ready = 1'b0;
    for (int v = 0; v < NUM_VEC; v++) begin
      build_vector(v);
    end
    for (int v = 0; v < NUM_VEC; v++) begin
      model_vector(v * softmax_pkg::VEC_LEN);
    end

    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    while (out_count < NUM_ELEM) begin
      @(negedge clk);
      if (in_fire) begin
        idx++;
      end
      // heavy back-pressure window fills both FIFOs
      if (idx >= 96 && idx < 192) begin
        out_ready = ($urandom_range(0, 3) == 0);
      end else begin
        out_ready = ($urandom_range(0, 3) != 0);
      end
      if (idx >= NUM_ELEM) begin
        in_valid = 1'b0;
      end else if (!in_valid || in_fire) begin
        in_valid = ($urandom_range(0, 3) != 0); // random gaps
        in_data = stim[idx];
      end
    end

    out_ready = 1'b1;
    repeat (20) @(negedge clk); // any extra beat shows up here
    a_count: assert (out_count == NUM_ELEM && expect_q.size() == 0) else begin
      value_errors++;
      $display("FAILED output count: got %h expected %h", out_count, NUM_ELEM);
    end

    $display("outputs %0d of %0d, value errors %0d, protocol errors %0d",
             out_count, NUM_ELEM, value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
src/softmax_pkg.sv
src/stream_fifo.sv
src/exp_lut.sv
src/exp_sum_accumulator.sv
src/sum_hold_buffer.sv
src/softmax_divider.sv
src/fixed_softmax.sv
bench/softmax_tb.sv

// ==== Bender.yml ====
package:
  name: fixed_softmax

sources:
  - src/softmax_pkg.sv
  - src/stream_fifo.sv
  - src/exp_lut.sv
  - src/exp_sum_accumulator.sv
  - src/sum_hold_buffer.sv
  - src/softmax_divider.sv
  - src/fixed_softmax.sv
  - target: test
    files:
      - bench/softmax_tb.sv
